/* design/dct_pkg.sv */
package dct_pkg;

    // block geometry
    localparam int BLOCK_LEN = 8;
    localparam int HALF_LEN  = BLOCK_LEN / 2;

    // datapath widths
    localparam int SAMPLE_W = 17;
    // sample width rounded up to whole bytes
    localparam int STREAM_W = 8 * ((SAMPLE_W - 1) / 8 + 1);
    // cosine constants carry 7 fractional bits
    localparam int SCALE_SHIFT = 7;
    // butterfly sum times constant, and the sum of four such products
    localparam int PROD_W = 2 * SAMPLE_W + 1;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [STREAM_W-1:0] stream_t;
    typedef logic signed [PROD_W-1:0]   coef_t;
    typedef logic        [2:0]          col_idx_t;
    typedef logic        [1:0]          pair_idx_t;

    typedef enum logic [1:0]
    {
        COLLECT,
        COMPUTE,
        SEND
    } core_state_t;

    // row k holds the constants for coefficient k
    // even rows pair with x[m]+x[7-m], odd rows with x[m]-x[7-m]
    localparam sample_t COS_TABLE [BLOCK_LEN][HALF_LEN] = '{
        '{ 45,  45,  45,  45},
        '{ 63,  53,  36,  12},
        '{ 59,  24, -24, -59},
        '{ 53, -12, -63, -36},
        '{ 45, -45, -45,  45},
        '{ 36, -63,  12,  53},
        '{ 24, -59,  59, -24},
        '{ 12, -36,  53, -63}
    };

endpackage

/* design/dct_sample_buffer.sv */
`timescale 1ns/100ps

module dct_sample_buffer
(
    input  logic             i_clk,
    input  logic             i_aresetn,
    input  logic             i_collect,
    input  logic             i_s_valid,
    input  dct_pkg::stream_t i_s_data,
    input  logic             i_s_last,
    input  logic             i_clear,
    output logic             o_s_ready,
    output logic             o_block_done,
    output dct_pkg::sample_t o_samples [dct_pkg::BLOCK_LEN]
);

    import dct_pkg::*;

    sample_t  r_store [BLOCK_LEN];
    col_idx_t r_col;
    logic     w_accept;

    // only open while the sequencer is collecting
    assign o_s_ready = i_collect;
    assign w_accept  = i_s_valid && i_collect;

    // block ends on the eighth sample or on an early last
    assign o_block_done = w_accept && (i_s_last || (r_col == col_idx_t'(BLOCK_LEN - 1)));

    always_ff @(posedge i_clk)
    begin
        if (!i_aresetn)
        begin
            r_col <= '0;
            for (int i = 0; i < BLOCK_LEN; i++)
            begin
                r_store[i] <= '0;
            end
        end
        else
        begin
            // unwritten positions of a short block must read as zero
            if (i_clear)
            begin
                for (int i = 0; i < BLOCK_LEN; i++)
                begin
                    r_store[i] <= '0;
                end
            end
            if (w_accept)
            begin
                r_store[r_col] <= i_s_data[SAMPLE_W-1:0];
                if (o_block_done)
                begin
                    r_col <= '0;
                end
                else
                begin
                    r_col <= r_col + 1'b1;
                end
            end
        end
    end

    assign o_samples = r_store;

    // collection only stops on a block boundary, no half-written block left behind
    a_no_write_outside_collect: assert property (
        @(posedge i_clk) disable iff (!i_aresetn)
        !i_collect |-> (r_col == '0)
    );

endmodule

/* design/dct_core_ctrl.sv */
`timescale 1ns/100ps

module dct_core_ctrl
(
    input  logic               i_clk,
    input  logic               i_aresetn,
    input  logic               i_block_done,
    input  logic               i_res_valid,
    input  dct_pkg::pair_idx_t i_res_pair,
    input  logic               i_send_done,
    output logic               o_collect,
    output logic               o_issue_valid,
    output dct_pkg::pair_idx_t o_issue_pair,
    output logic               o_send
);

    import dct_pkg::*;

    core_state_t r_state;
    pair_idx_t   r_pair;
    logic        r_issuing;
    logic        r_send;
    logic        w_last_result;

    // pair 3 is always the final one out of the pipeline
    assign w_last_result = i_res_valid && (i_res_pair == pair_idx_t'(HALF_LEN - 1));

    always_ff @(posedge i_clk)
    begin
        if (!i_aresetn)
        begin
            r_state   <= COLLECT;
            r_pair    <= '0;
            r_issuing <= 1'b0;
            r_send    <= 1'b0;
        end
        else
        begin
            r_send <= 1'b0;
            case (r_state)
                COLLECT:
                begin
                    if (i_block_done)
                    begin
                        r_state   <= COMPUTE;
                        r_pair    <= '0;
                        r_issuing <= 1'b1;
                    end
                end
                COMPUTE:
                begin
                    // one pair per cycle, four in a row
                    if (r_issuing)
                    begin
                        if (r_pair == pair_idx_t'(HALF_LEN - 1))
                        begin
                            r_issuing <= 1'b0;
                        end
                        else
                        begin
                            r_pair <= r_pair + 1'b1;
                        end
                    end
                    if (w_last_result)
                    begin
                        r_state <= SEND;
                        r_send  <= 1'b1;
                    end
                end
                SEND:
                begin
                    // stalls here for as long as the output is held off
                    if (i_send_done)
                    begin
                        r_state <= COLLECT;
                    end
                end
                default:
                begin
                    r_state <= COLLECT;
                end
            endcase
        end
    end

    assign o_collect     = (r_state == COLLECT);
    assign o_issue_valid = r_issuing;
    assign o_issue_pair  = r_pair;
    assign o_send        = r_send;

    a_issue_in_compute: assert property (
        @(posedge i_clk) disable iff (!i_aresetn)
        o_issue_valid |-> (r_state == COMPUTE)
    );

endmodule

/* design/dct_butterfly_mac.sv */
`timescale 1ns/100ps

module dct_butterfly_mac
(
    input  logic               i_clk,
    input  logic               i_aresetn,
    input  logic               i_issue_valid,
    input  dct_pkg::pair_idx_t i_issue_pair,
    input  dct_pkg::sample_t   i_samples [dct_pkg::BLOCK_LEN],
    output logic               o_res_valid,
    output dct_pkg::pair_idx_t o_res_pair,
    output dct_pkg::coef_t     o_even_coef,
    output dct_pkg::coef_t     o_odd_coef
);

    import dct_pkg::*;

    // one extra bit for the pre-add
    logic signed [SAMPLE_W:0] r_s1_sum  [HALF_LEN];
    logic signed [SAMPLE_W:0] r_s1_diff [HALF_LEN];
    sample_t   r_s1_even_row [HALF_LEN];
    sample_t   r_s1_odd_row  [HALF_LEN];
    logic      r_s1_valid;
    pair_idx_t r_s1_pair;

    coef_t     r_s2_even_prod [HALF_LEN];
    coef_t     r_s2_odd_prod  [HALF_LEN];
    logic      r_s2_valid;
    pair_idx_t r_s2_pair;

    coef_t     r_s3_even;
    coef_t     r_s3_odd;
    logic      r_s3_valid;
    pair_idx_t r_s3_pair;

    col_idx_t  w_even_row;
    col_idx_t  w_odd_row;
    coef_t     w_even_sum;
    coef_t     w_odd_sum;

    // pair p serves coefficients 2p and 2p+1
    assign w_even_row = {i_issue_pair, 1'b0};
    assign w_odd_row  = {i_issue_pair, 1'b1};

    // valid bits travel alongside the payload
    always_ff @(posedge i_clk)
    begin
        if (!i_aresetn)
        begin
            r_s1_valid <= 1'b0;
            r_s2_valid <= 1'b0;
            r_s3_valid <= 1'b0;
        end
        else
        begin
            r_s1_valid <= i_issue_valid;
            r_s2_valid <= r_s1_valid;
            r_s3_valid <= r_s2_valid;
        end
    end

    // stage 1: butterfly and constant fetch
    always_ff @(posedge i_clk)
    begin
        r_s1_pair <= i_issue_pair;
        for (int m = 0; m < HALF_LEN; m++)
        begin
            r_s1_sum[m]      <= i_samples[m] + i_samples[BLOCK_LEN-1-m];
            r_s1_diff[m]     <= i_samples[m] - i_samples[BLOCK_LEN-1-m];
            r_s1_even_row[m] <= COS_TABLE[w_even_row][m];
            r_s1_odd_row[m]  <= COS_TABLE[w_odd_row][m];
        end
    end

    // stage 2: eight products
    always_ff @(posedge i_clk)
    begin
        r_s2_pair <= r_s1_pair;
        for (int m = 0; m < HALF_LEN; m++)
        begin
            r_s2_even_prod[m] <= r_s1_sum[m] * r_s1_even_row[m];
            r_s2_odd_prod[m]  <= r_s1_diff[m] * r_s1_odd_row[m];
        end
    end

    always_comb
    begin
        w_even_sum = '0;
        w_odd_sum  = '0;
        for (int m = 0; m < HALF_LEN; m++)
        begin
            w_even_sum = w_even_sum + r_s2_even_prod[m];
            w_odd_sum  = w_odd_sum + r_s2_odd_prod[m];
        end
    end

    // stage 3: single shift on the full sum, sign kept
    always_ff @(posedge i_clk)
    begin
        r_s3_pair <= r_s2_pair;
        r_s3_even <= w_even_sum >>> SCALE_SHIFT;
        r_s3_odd  <= w_odd_sum >>> SCALE_SHIFT;
    end

    assign o_res_valid = r_s3_valid;
    assign o_res_pair  = r_s3_pair;
    assign o_even_coef = r_s3_even;
    assign o_odd_coef  = r_s3_odd;

endmodule

/* design/dct_result_buffer.sv */
`timescale 1ns/100ps

module dct_result_buffer
(
    input  logic               i_clk,
    input  logic               i_aresetn,
    input  logic               i_res_valid,
    input  dct_pkg::pair_idx_t i_res_pair,
    input  dct_pkg::coef_t     i_even_coef,
    input  dct_pkg::coef_t     i_odd_coef,
    input  logic               i_send,
    input  logic               i_m_ready,
    output logic               o_m_valid,
    output dct_pkg::stream_t   o_m_data,
    output logic               o_m_last,
    output logic               o_send_done
);

    import dct_pkg::*;

    coef_t    r_coef [BLOCK_LEN];
    logic     r_valid;
    col_idx_t r_idx;
    logic     w_beat;

    // coefficient store, written two at a time
    always_ff @(posedge i_clk)
    begin
        if (i_res_valid)
        begin
            r_coef[{i_res_pair, 1'b0}] <= i_even_coef;
            r_coef[{i_res_pair, 1'b1}] <= i_odd_coef;
        end
    end

    assign w_beat = r_valid && i_m_ready;

    always_ff @(posedge i_clk)
    begin
        if (!i_aresetn)
        begin
            r_valid <= 1'b0;
            r_idx   <= '0;
        end
        else if (i_send)
        begin
            r_valid <= 1'b1;
            r_idx   <= '0;
        end
        else if (w_beat)
        begin
            if (r_idx == col_idx_t'(BLOCK_LEN - 1))
            begin
                r_valid <= 1'b0;
                r_idx   <= '0;
            end
            else
            begin
                r_idx <= r_idx + 1'b1;
            end
        end
    end

    // index only moves on a beat, so data holds under back-pressure
    assign o_m_valid   = r_valid;
    assign o_m_data    = r_coef[r_idx][STREAM_W-1:0];
    assign o_m_last    = (r_idx == col_idx_t'(BLOCK_LEN - 1));
    assign o_send_done = w_beat && o_m_last;

    a_hold_under_stall: assert property (
        @(posedge i_clk) disable iff (!i_aresetn)
        (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data) && $stable(o_m_last))
    );

endmodule

/* design/dct_1d_top.sv */
`timescale 1ns/100ps

module dct_1d_top
(
    input  logic             i_clk,
    input  logic             i_aresetn,
    // input stream
    input  logic             i_s_valid,
    output logic             o_s_ready,
    input  dct_pkg::stream_t i_s_data,
    input  logic             i_s_last,
    // output stream
    output logic             o_m_valid,
    input  logic             i_m_ready,
    output dct_pkg::stream_t o_m_data,
    output logic             o_m_last
);

    import dct_pkg::*;

    logic      w_collect;
    logic      w_block_done;
    sample_t   w_samples [BLOCK_LEN];
    logic      w_issue_valid;
    pair_idx_t w_issue_pair;
    logic      w_res_valid;
    pair_idx_t w_res_pair;
    coef_t     w_even_coef;
    coef_t     w_odd_coef;
    logic      w_send;
    logic      w_send_done;

    dct_sample_buffer sample_buffer_i
    (
        .i_clk        (i_clk),
        .i_aresetn    (i_aresetn),
        .i_collect    (w_collect),
        .i_s_valid    (i_s_valid),
        .i_s_data     (i_s_data),
        .i_s_last     (i_s_last),
        .i_clear      (w_send_done),
        .o_s_ready    (o_s_ready),
        .o_block_done (w_block_done),
        .o_samples    (w_samples)
    );

    dct_core_ctrl core_ctrl_i
    (
        .i_clk         (i_clk),
        .i_aresetn     (i_aresetn),
        .i_block_done  (w_block_done),
        .i_res_valid   (w_res_valid),
        .i_res_pair    (w_res_pair),
        .i_send_done   (w_send_done),
        .o_collect     (w_collect),
        .o_issue_valid (w_issue_valid),
        .o_issue_pair  (w_issue_pair),
        .o_send        (w_send)
    );

    dct_butterfly_mac butterfly_mac_i
    (
        .i_clk         (i_clk),
        .i_aresetn     (i_aresetn),
        .i_issue_valid (w_issue_valid),
        .i_issue_pair  (w_issue_pair),
        .i_samples     (w_samples),
        .o_res_valid   (w_res_valid),
        .o_res_pair    (w_res_pair),
        .o_even_coef   (w_even_coef),
        .o_odd_coef    (w_odd_coef)
    );

    dct_result_buffer result_buffer_i
    (
        .i_clk       (i_clk),
        .i_aresetn   (i_aresetn),
        .i_res_valid (w_res_valid),
        .i_res_pair  (w_res_pair),
        .i_even_coef (w_even_coef),
        .i_odd_coef  (w_odd_coef),
        .i_send      (w_send),
        .i_m_ready   (i_m_ready),
        .o_m_valid   (o_m_valid),
        .o_m_data    (o_m_data),
        .o_m_last    (o_m_last),
        .o_send_done (w_send_done)
    );

endmodule

/* dv/dct_clk_gen.sv */
`timescale 1ns/100ps

module dct_clk_gen
(
    output logic o_clk,
    output logic o_aresetn
);

    // 4 ns period
    initial
    begin
        o_clk = 1'b0;
        forever
        begin
            #2 o_clk = ~o_clk;
        end
    end

    // low over four rising edges, released on a falling edge
    initial
    begin
        o_aresetn = 1'b0;
        repeat (4) @(posedge o_clk);
        @(negedge o_clk);
        o_aresetn = 1'b1;
    end

endmodule

/* dv/dct_1d_tb.sv */
`timescale 1ns/100ps

module dct_1d_tb;

    import dct_pkg::*;

    // record layout in the stimulus file
    localparam int REC_LEN    = 20;
    localparam int MAX_BLOCKS = 32;
    localparam int SAMPLE_OFS = 4;
    localparam int EXPECT_OFS = 12;

    logic    clk;
    logic    aresetn;
    logic    s_valid;
    stream_t s_data;
    logic    s_last;
    logic    s_ready;
    logic    m_valid;
    logic    m_ready;
    stream_t m_data;
    logic    m_last;

    logic [STREAM_W-1:0] stim_mem [1 + MAX_BLOCKS * REC_LEN];

    integer seed         = 32'h6b89;
    int     errors       = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     num_blocks   = 0;
    int     cycles       = 0;
    int     cycle_limit  = 0;
    int     current_test = 0;

    dct_clk_gen clk_gen_i
    (
        .o_clk     (clk),
        .o_aresetn (aresetn)
    );

    dct_1d_top dut_i
    (
        .i_clk     (clk),
        .i_aresetn (aresetn),
        .i_s_valid (s_valid),
        .o_s_ready (s_ready),
        .i_s_data  (s_data),
        .i_s_last  (s_last),
        .o_m_valid (m_valid),
        .i_m_ready (m_ready),
        .o_m_data  (m_data),
        .o_m_last  (m_last)
    );

    task automatic check_value(input string name, input logic [STREAM_W-1:0] got,
                               input logic [STREAM_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s in test %0d: got %h, expected %h", name, current_test, got, exp);
            errors++;
        end
    endtask

    // feeds one block and collects its eight coefficients, one cycle per pass
    task automatic run_block(input int base);
        int      count;
        logic    gap;
        logic    stall;
        int      n_in;
        int      n_out;
        int      errors_before;
        sample_t smp;
        current_test  = int'(stim_mem[base]);
        count         = int'(stim_mem[base + 1]);
        gap           = stim_mem[base + 2][0];
        stall         = stim_mem[base + 3][0];
        n_in          = 0;
        n_out         = 0;
        errors_before = errors;
        if (count < 1 || count > BLOCK_LEN)
        begin
            $display("Test %0d has sample count %0d, outside 1 to 8", current_test, count);
            errors++;
        end
        else
        begin
            while (n_out < BLOCK_LEN)
            begin
                @(negedge clk);
                if (n_in < count && !(gap && (($random(seed) & 3) == 0)))
                begin
                    smp     = sample_t'(stim_mem[base + SAMPLE_OFS + n_in]);
                    s_valid = 1'b1;
                    s_data  = {{(STREAM_W - SAMPLE_W){smp[SAMPLE_W-1]}}, smp};
                    s_last  = (n_in == count - 1);
                end
                else
                begin
                    s_valid = 1'b0;
                    s_last  = 1'b0;
                end
                m_ready = !(stall && (($random(seed) & 3) == 0));
                // outputs only move on the rising edge, settled here
                if (n_in == count && s_ready)
                begin
                    $display("Input ready was high while test %0d was in progress",
                             current_test);
                    errors++;
                end
                if (n_in < count && !s_ready)
                begin
                    $display("Input ready was low while test %0d was still collecting",
                             current_test);
                    errors++;
                end
                if (n_in < count && m_valid)
                begin
                    $display("Output valid was high with no block pending in test %0d",
                             current_test);
                    errors++;
                end
                if (s_valid && s_ready)
                begin
                    n_in++;
                end
                if (m_valid && m_ready)
                begin
                    check_value("o_m_data", m_data, stim_mem[base + EXPECT_OFS + n_out]);
                    check_value("o_m_last", STREAM_W'(m_last), STREAM_W'(n_out == BLOCK_LEN - 1));
                    n_out++;
                end
                @(posedge clk);
            end
        end
        if (errors == errors_before)
        begin
            tests_passed++;
            $display("block %0d ok: %0d samples, gap %0d, stall %0d", current_test, count, gap,
                     stall);
        end
        else
        begin
            tests_failed++;
            $display("block %0d had %0d errors", current_test, errors - errors_before);
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles in test %0d, output beats missing", cycles,
                     current_test);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        s_valid = 1'b0;
        s_data  = '0;
        s_last  = 1'b0;
        m_ready = 1'b1;
        $readmemh("dv/dct_stim.txt", stim_mem);
        num_blocks = int'(stim_mem[0]);
        if (num_blocks < 1 || num_blocks > MAX_BLOCKS)
        begin
            $display("Stimulus file gives %0d blocks, expected 1 to %0d", num_blocks, MAX_BLOCKS);
            errors++;
            num_blocks = 0;
        end
        cycle_limit = num_blocks * 100;
        wait (aresetn);
        @(negedge clk);
        check_value("o_m_valid", STREAM_W'(m_valid), '0);
        check_value("o_m_last", STREAM_W'(m_last), '0);
        check_value("o_s_ready", STREAM_W'(s_ready), STREAM_W'(1));
        for (int b = 0; b < num_blocks; b++)
        begin
            run_block(1 + b * REC_LEN);
        end
        $display("blocks %0d, passed %0d, failed %0d, errors %0d", num_blocks, tests_passed,
                 tests_failed, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* list.f */
design/dct_pkg.sv
design/dct_sample_buffer.sv
design/dct_core_ctrl.sv
design/dct_butterfly_mac.sv
design/dct_result_buffer.sv
design/dct_1d_top.sv
dv/dct_clk_gen.sv
dv/dct_1d_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the DCT testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module dct_1d_tb --Mdir "$BUILD_DIR" -o dct_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/dct_sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* dv/dct_stim.txt */
// first value is the block count; each block then takes two lines
// id count gap stall, eight 17-bit samples / eight expected 24-bit coefficients
6
// full ramp
1 8 0 0  00000 00001 00002 00003 00004 00005 00006 00007
000009 FFFFF9 000000 FFFFFF 000000 FFFFFF 000000 000000
// alternating extremes, output stalls
2 8 0 1  0FFFF 10000 0FFFF 10000 0FFFF 10000 0FFFF 10000
FFFFFE 0087FF 000000 0097FF 000000 00E7FF 000000 028FFE
// three samples then last, right after a full block
3 3 0 0  00064 1FFCE 00014 00000 00000 00000 00000 00000
000018 000022 000020 000024 00002D 000036 000033 00001F
// ramp again with input gaps and output stalls
4 8 1 1  00000 00001 00002 00003 00004 00005 00006 00007
000009 FFFFF9 000000 FFFFFF 000000 FFFFFF 000000 000000
// reversed extremes, negative odd terms, input gaps
5 8 1 0  10000 0FFFF 10000 0FFFF 10000 0FFFF 10000 0FFFF
FFFFFE FF7800 000000 FF6800 000000 FF1800 000000 FD7001
// single sample of minus one after a full block
6 1 1 1  1FFFF 00000 00000 00000 00000 00000 00000 00000
FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF FFFFFF
